//--- src/mem_pkg.sv
package mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry of the shared memory port
  ////////////////////////////////////////////////////////////////////////////

  // One cache block, seen by the caches as a single vector
  localparam int BLK_SIZE   = 128;
  localparam int LANE_W     = 32;
  // One bank per 32-bit word of the block
  localparam int LANES      = BLK_SIZE / LANE_W;
  localparam int LANE_BYTES = LANE_W / 8;
  // Byte enables for the whole block
  localparam int MASK_W     = BLK_SIZE / 8;
  localparam int BOFFSET    = $clog2(MASK_W);
  localparam int IDX_W      = 6;
  localparam int DEPTH      = 1 << IDX_W;
  localparam int ADDR_W     = 32;

  // Cycles from the accept edge to the ready pulse
  localparam int MEM_LAT    = 3;
  localparam int CNT_W      = $clog2(MEM_LAT);

  ////////////////////////////////////////////////////////////////////////////
  // Request and response types
  ////////////////////////////////////////////////////////////////////////////

  // Store size of a data-cache write
  typedef enum logic [2:0] {
    NO_SIZE,
    BYTE,
    HALF_WORD,
    WORD,
    BLOCK
  } size_e;

  // Block word, either whole or split into bank lanes
  // Lane 0 sits in the low 32 bits
  typedef union packed {
    logic [BLK_SIZE-1:0]               blk;
    logic [LANES-1:0][LANE_W-1:0]      lane;
  } blk_u;

  // Instruction cache only reads
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } ilow_req_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic              rw;       // high for a write
    size_e             rw_size;
    blk_u              data;
  } dlow_req_t;

  // Same response shape for both caches
  typedef struct packed {
    logic valid;
    blk_u blk;
  } low_res_t;

  // Arbiter output to the banks and the controller
  typedef struct packed {
    logic              valid;
    logic [IDX_W-1:0]  index;
    logic [MASK_W-1:0] wmask;
    blk_u              data;
  } mem_req_t;

endpackage

//--- src/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  mem_pkg::ilow_req_t icache_req_i,
  input  mem_pkg::dlow_req_t dcache_req_i,
  input  logic               mem_ready_i,
  input  mem_pkg::blk_u      rdata_i,
  output mem_pkg::low_res_t  icache_res_o,
  output mem_pkg::low_res_t  dcache_res_o,
  output mem_pkg::mem_req_t  mem_req_o
);

  // Which cache owns the memory port
  typedef enum logic [1:0] {
    IDLE,
    ICACHE,
    DCACHE
  } round_e;

  round_e                       round_q;
  round_e                       round_d;
  logic                         last_dc_q;
  logic                         issue_q;
  logic                         free;
  logic                         ic_cand;
  logic                         dc_cand;
  logic [mem_pkg::BOFFSET-1:0]  offset;
  logic [mem_pkg::MASK_W-1:0]   wmask;
  logic [mem_pkg::ADDR_W-1:0]   addr;

  ////////////////////////////////////////////////////////////////////////////
  // Round selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Port can be handed over when idle or when the access completes
    free = (round_q == IDLE) || mem_ready_i;
    // The cache finishing now still shows its old valid, skip it
    ic_cand = icache_req_i.valid && !(mem_ready_i && round_q == ICACHE);
    dc_cand = dcache_req_i.valid && !(mem_ready_i && round_q == DCACHE);
    round_d = round_q;
    if (free) begin
      if (ic_cand && dc_cand) begin
        // Both waiting, serve the one not served last
        round_d = last_dc_q ? ICACHE : DCACHE;
      end else if (ic_cand) begin
        round_d = ICACHE;
      end else if (dc_cand) begin
        round_d = DCACHE;
      end else begin
        round_d = IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      round_q   <= IDLE;
      last_dc_q <= 1'b0;
      issue_q   <= 1'b0;
    end else begin
      round_q <= round_d;
      // Valid to the controller only in the first cycle of a round
      issue_q <= free && (round_d != IDLE);
      if (free && round_d != IDLE) begin
        last_dc_q <= (round_d == DCACHE);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request mux and byte mask
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    addr   = (round_q == DCACHE) ? dcache_req_i.addr : icache_req_i.addr;
    offset = dcache_req_i.addr[mem_pkg::BOFFSET-1:0];
    wmask  = '0;
    // Reads and icache rounds leave the mask at zero
    if (round_q == DCACHE && dcache_req_i.rw) begin
      case (dcache_req_i.rw_size)
        mem_pkg::BYTE:      wmask = mem_pkg::MASK_W'(4'h1) << offset;
        mem_pkg::HALF_WORD: wmask = mem_pkg::MASK_W'(4'h3) << offset;
        mem_pkg::WORD:      wmask = mem_pkg::MASK_W'(4'hf) << offset;
        mem_pkg::BLOCK:     wmask = '1;
        default:            wmask = '0;
      endcase
    end

    mem_req_o.valid = issue_q;
    mem_req_o.index = addr[mem_pkg::BOFFSET +: mem_pkg::IDX_W];
    // Mask only while the strobe can be raised
    mem_req_o.wmask = issue_q ? wmask : '0;
    mem_req_o.data  = dcache_req_i.data;
  end

  // Responses share the read block, valid follows the round
  always_comb begin
    icache_res_o.valid = (round_q == ICACHE) && mem_ready_i;
    icache_res_o.blk   = rdata_i;
    dcache_res_o.valid = (round_q == DCACHE) && mem_ready_i;
    dcache_res_o.blk   = rdata_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Ownership holds for the whole access
  a_round_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (!mem_ready_i && round_q != IDLE) |=> $stable(round_q)
  ) else $error("arbiter round changed during an access");

endmodule

//--- src/mem_bank.sv
`timescale 1ns/1ps

module mem_bank (
  input  logic                              clk_i,
  input  logic                              acc_i,
  input  logic [mem_pkg::IDX_W-1:0]         index_i,
  input  logic [mem_pkg::LANE_BYTES-1:0]    wmask_i,
  input  logic [mem_pkg::LANE_W-1:0]        wdata_i,
  output logic [mem_pkg::LANE_W-1:0]        rdata_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Lane storage
  ////////////////////////////////////////////////////////////////////////////

  // One 32-bit word of every block
  logic [mem_pkg::LANE_W-1:0] mem_q [mem_pkg::DEPTH];
  logic [mem_pkg::LANE_W-1:0] rdata_q;

  // Read-before-write on the accept edge
  always_ff @(posedge clk_i) begin
    if (acc_i) begin
      rdata_q <= mem_q[index_i];
    end
  end

  // Byte enables, one per byte of the lane
  always_ff @(posedge clk_i) begin
    if (acc_i) begin
      for (int b = 0; b < mem_pkg::LANE_BYTES; b++) begin
        if (wmask_i[b]) begin
          mem_q[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Old word stays until the next access
  assign rdata_o = rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Arbiter only drives a mask in the cycle the controller strobes
  // Unknown strobe before reset is skipped
  a_mask_idle: assert property (
    @(posedge clk_i)
    (acc_i === 1'b0) |-> (wmask_i == '0)
  ) else $error("bank write mask set without access strobe");

endmodule

//--- src/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       req_valid_i,
  input  logic [mem_pkg::LANES-1:0][mem_pkg::LANE_W-1:0] lane_rdata_i,
  output logic                                       acc_o,
  output logic                                       mem_ready_o,
  output mem_pkg::blk_u                              rdata_o
);

  logic                      busy_q;
  logic                      ready_q;
  logic [mem_pkg::CNT_W-1:0] cnt_q;
  logic                      accept;

  ////////////////////////////////////////////////////////////////////////////
  // Accept strobe
  ////////////////////////////////////////////////////////////////////////////

  // Only one access in flight
  assign accept = req_valid_i && !busy_q;

  // Banks act on this edge, so the strobe is the accept itself
  assign acc_o = accept;

  ////////////////////////////////////////////////////////////////////////////
  // Latency counter and ready pulse
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      ready_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      if (accept) begin
        busy_q  <= 1'b1;
        ready_q <= 1'b0;
        // Count down the remaining cycles after the accept cycle
        cnt_q   <= mem_pkg::CNT_W'(mem_pkg::MEM_LAT - 1);
      end else if (ready_q) begin
        // Pulse done, port free on the same edge the arbiter moves
        busy_q  <= 1'b0;
        ready_q <= 1'b0;
      end else if (busy_q) begin
        if (cnt_q != '0) begin
          cnt_q <= cnt_q - mem_pkg::CNT_W'(1);
        end
        // Last counted cycle, raise ready next
        ready_q <= (cnt_q == mem_pkg::CNT_W'(1));
      end
    end
  end

  assign mem_ready_o = ready_q;

  ////////////////////////////////////////////////////////////////////////////
  // Read block assembly
  ////////////////////////////////////////////////////////////////////////////

  // Lane i of the block comes from bank i
  always_comb begin
    for (int i = 0; i < mem_pkg::LANES; i++) begin
      rdata_o.lane[i] = lane_rdata_i[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Ready pulse belongs to an accepted access
  a_ready_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_ready_o |-> busy_q
  ) else $error("ready pulse without an access in flight");

  // Ready comes a fixed latency after the accept strobe
  a_ready_lat: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_ready_o |-> $past(acc_o, mem_pkg::MEM_LAT)
  ) else $error("ready pulse off the access latency");

endmodule

//--- src/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  mem_pkg::ilow_req_t icache_req_i,
  input  mem_pkg::dlow_req_t dcache_req_i,
  output mem_pkg::low_res_t  icache_res_o,
  output mem_pkg::low_res_t  dcache_res_o
);

  mem_pkg::mem_req_t                              mem_req;
  mem_pkg::blk_u                                  rdata;
  logic                                           acc;
  logic                                           mem_ready;
  logic [mem_pkg::LANES-1:0][mem_pkg::LANE_W-1:0] lane_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Cache arbitration
  ////////////////////////////////////////////////////////////////////////////

  memory_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .icache_req_i (icache_req_i),
    .dcache_req_i (dcache_req_i),
    .mem_ready_i  (mem_ready),
    .rdata_i      (rdata),
    .icache_res_o (icache_res_o),
    .dcache_res_o (dcache_res_o),
    .mem_req_o    (mem_req)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Word-lane banks
  ////////////////////////////////////////////////////////////////////////////

  // Bank g holds lane g, with its slice of the byte mask
  for (genvar g = 0; g < mem_pkg::LANES; g++) begin : g_bank
    mem_bank u_bank (
      .clk_i   (clk_i),
      .acc_i   (acc),
      .index_i (mem_req.index),
      .wmask_i (mem_req.wmask[g*mem_pkg::LANE_BYTES +: mem_pkg::LANE_BYTES]),
      .wdata_i (mem_req.data.lane[g]),
      .rdata_o (lane_rdata[g])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Access timing
  ////////////////////////////////////////////////////////////////////////////

  mem_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (mem_req.valid),
    .lane_rdata_i (lane_rdata),
    .acc_o        (acc),
    .mem_ready_o  (mem_ready),
    .rdata_o      (rdata)
  );

endmodule

//--- sim/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int TIMEOUT_CYC = 40;
  localparam int NIDX        = 1 << mem_pkg::IDX_W;

  logic               clk_i;
  logic               rst_ni;
  mem_pkg::ilow_req_t icache_req;
  mem_pkg::dlow_req_t dcache_req;
  mem_pkg::low_res_t  icache_res;
  mem_pkg::low_res_t  dcache_res;

  // Cache-side copy of the memory, known once a full block was written
  logic [mem_pkg::BLK_SIZE-1:0] model_mem [NIDX];
  bit                           known [NIDX];
  logic [31:0]                  lfsr_q;
  // Completion order, high for a data-cache response
  logic                         order_q [$];
  int                           errors;
  int                           timeouts;
  int                           checks;

  mem_subsys_top dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .icache_req_i (icache_req),
    .dcache_req_i (dcache_req),
    .icache_res_o (icache_res),
    .dcache_res_o (dcache_res)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [mem_pkg::BLK_SIZE-1:0] rand_bits(input int n);
    logic [mem_pkg::BLK_SIZE-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i]   = lfsr_q[0];
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [31:0] make_addr(input int idx, input int off);
    return (32'(idx) << mem_pkg::BOFFSET) | 32'(off);
  endfunction

  // Byte enables as the caches expect them
  function automatic logic [15:0] byte_mask(input logic rw, input mem_pkg::size_e size,
                                            input logic [3:0] offset);
    logic [15:0] m;
    m = '0;
    if (rw) begin
      case (size)
        mem_pkg::BYTE:      m = 16'h0001 << offset;
        mem_pkg::HALF_WORD: m = 16'h0003 << offset;
        mem_pkg::WORD:      m = 16'h000f << offset;
        mem_pkg::BLOCK:     m = 16'hffff;
        default:            m = '0;
      endcase
    end
    return m;
  endfunction

  function automatic logic [127:0] merge(input logic [127:0] old, input logic [127:0] data,
                                         input logic [15:0] mask);
    logic [127:0] r;
    r = old;
    for (int b = 0; b < 16; b++) begin
      if (mask[b]) r[8*b +: 8] = data[8*b +: 8];
    end
    return r;
  endfunction

  task automatic check_blk(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
    checks++;
    a_blk: assert (got === exp) else begin
      errors++;
      $display("error %0t: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idle(input string what);
    checks++;
    a_idle: assert (!icache_res.valid && !dcache_res.valid) else begin
      errors++;
      $display("error %0t: response valid high %s", $time, what);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Cache requests
  ////////////////////////////////////////////////////////////////////////////

  // Holds the request until its response, the old block is checked
  task automatic dcache_op(input logic [31:0] addr, input logic rw,
                           input mem_pkg::size_e size, input logic [127:0] data);
    int           idx;
    bit           done;
    logic [15:0]  mask;
    logic [127:0] exp_old;
    idx     = addr[mem_pkg::BOFFSET +: mem_pkg::IDX_W];
    mask    = byte_mask(rw, size, addr[3:0]);
    exp_old = model_mem[idx];
    dcache_req.addr     = addr;
    dcache_req.rw       = rw;
    dcache_req.rw_size  = size;
    dcache_req.data.blk = data;
    dcache_req.valid    = 1'b1;
    done = 1'b0;
    for (int cyc = 0; cyc < TIMEOUT_CYC && !done; cyc++) begin
      @(negedge clk_i);
      if (dcache_res.valid) done = 1'b1;
    end
    if (!done) begin
      timeouts++;
      $display("Timeout: no data cache response for address %h", addr);
    end else begin
      if (known[idx]) check_blk("data cache", dcache_res.blk.blk, exp_old);
      model_mem[idx] = merge(exp_old, data, mask);
      if (mask == 16'hffff) known[idx] = 1'b1;
      order_q.push_back(1'b1);
    end
    dcache_req.valid = 1'b0;
  endtask

  task automatic icache_read(input logic [31:0] addr);
    int idx;
    bit done;
    idx = addr[mem_pkg::BOFFSET +: mem_pkg::IDX_W];
    icache_req.addr  = addr;
    icache_req.valid = 1'b1;
    done = 1'b0;
    for (int cyc = 0; cyc < TIMEOUT_CYC && !done; cyc++) begin
      @(negedge clk_i);
      if (icache_res.valid) done = 1'b1;
    end
    if (!done) begin
      timeouts++;
      $display("Timeout: no instruction cache response for address %h", addr);
    end else begin
      if (known[idx]) check_blk("instruction cache", icache_res.blk.blk, model_mem[idx]);
      order_q.push_back(1'b0);
    end
    icache_req.valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_idle();
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      check_idle("with no request");
    end
  endtask

  // Fill every index, then rewrite a few and read them back
  task automatic test_block_rw();
    int sel [4] = '{3, 17, 42, 63};
    for (int i = 0; i < NIDX; i++) begin
      dcache_op(make_addr(i, 0), 1'b1, mem_pkg::BLOCK, rand_bits(128));
    end
    foreach (sel[i]) dcache_op(make_addr(sel[i], 0), 1'b1, mem_pkg::BLOCK, rand_bits(128));
    foreach (sel[i]) icache_read(make_addr(sel[i], 8));
    for (int i = 0; i < NIDX; i += 5) icache_read(make_addr(i, 0));
  endtask

  // Sub-word stores, each followed by a data-cache read of the block
  task automatic test_sub_word();
    mem_pkg::size_e sizes [8] = '{mem_pkg::BYTE, mem_pkg::BYTE, mem_pkg::HALF_WORD,
                                  mem_pkg::HALF_WORD, mem_pkg::WORD, mem_pkg::WORD,
                                  mem_pkg::NO_SIZE, mem_pkg::WORD};
    int offs [8] = '{0, 9, 2, 15, 4, 13, 6, 11};
    int idx;
    for (int i = 0; i < 8; i++) begin
      idx = (5 + 7 * i) % NIDX;
      dcache_op(make_addr(idx, offs[i]), 1'b1, sizes[i], rand_bits(128));
      // Last one is a read with a size set, mask must stay zero
      dcache_op(make_addr(idx, 0), 1'b0, sizes[7 - i], rand_bits(128));
      dcache_op(make_addr(idx, 0), 1'b0, mem_pkg::NO_SIZE, '0);
    end
  endtask

  // Both caches keep valid high, completions must alternate
  task automatic test_contention();
    order_q.delete();
    fork
      for (int i = 0; i < 6; i++) icache_read(make_addr(2 * i + 1, 0));
      for (int i = 0; i < 6; i++) begin
        dcache_op(make_addr(2 * i + 20, 4), 1'b1, mem_pkg::WORD, rand_bits(128));
      end
    join
    checks++;
    a_count: assert (order_q.size() == 12) else begin
      errors++;
      $display("error %0t: %0d completions, expected 12", $time, order_q.size());
    end
    for (int i = 1; i < order_q.size(); i++) begin
      checks++;
      a_alt: assert (order_q[i] != order_q[i-1]) else begin
        errors++;
        $display("error %0t: completion %0d went to the same cache twice", $time, i);
      end
    end
  endtask

  // Reset in the middle of a read, then normal accesses again
  task automatic test_mid_reset();
    icache_req.addr  = make_addr(7, 0);
    icache_req.valid = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b0;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      check_idle("during reset");
    end
    icache_req.valid = 1'b0;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_idle("after reset");
    icache_read(make_addr(7, 0));
    dcache_op(make_addr(7, 1), 1'b1, mem_pkg::HALF_WORD, rand_bits(128));
    dcache_op(make_addr(7, 0), 1'b0, mem_pkg::NO_SIZE, '0);
  endtask

  initial begin
    rst_ni     = 1'b0;
    icache_req = '0;
    dcache_req = '0;
    lfsr_q     = 32'd78;
    errors     = 0;
    timeouts   = 0;
    checks     = 0;
    foreach (known[i]) known[i] = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    test_idle();
    test_block_rw();
    test_sub_word();
    test_contention();
    test_mid_reset();

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tb.f
src/mem_pkg.sv
src/memory_arbiter.sv
src/mem_bank.sv
src/mem_ctrl.sv
src/mem_subsys_top.sv
sim/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# Output goes to the terminal and through grep, the exit status comes from grep
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
